//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address width
`define XLEN 32

// Instruction memory, word addressed on the load port
`define IMEM_DEPTH 256
`define IMEM_AW 8

// Data memory, byte address taken modulo its size
`define DMEM_DEPTH 64
`define DMEM_AW 6

// Register index width
`define REG_ADDR_W 5

`endif

//--- design/cpu_pkg.sv
package cpu_pkg;

    // RISC-V major opcodes that the core executes
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // ALU operations decoded from funct3 and funct7 bit 30
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

//--- design/fetch_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module fetch_stage (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`IMEM_AW-1:0]    imem_addr,
    input  logic [`XLEN-1:0]       imem_wdata,
    output logic                   f_valid,
    output logic [`XLEN-1:0]       f_pc,
    output logic [`XLEN-1:0]       f_inst
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imem [`IMEM_DEPTH];
    logic [`IMEM_AW-1:0] fetch_idx;

    assign fetch_idx = pc[`IMEM_AW+1:2]; // Word index of pc

    // Program load port, only while the core is stopped
    always_ff @(posedge CLK) begin
        if (imem_we && (RST || !run)) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc      <= '0;
            f_valid <= 1'b0;
        end else if (run) begin
            pc      <= pc + `XLEN'd4;
            f_valid <= 1'b1;
        end else begin
            f_valid <= 1'b0; // Bubble, pc holds
        end
    end

    // Fetched word and its pc
    always_ff @(posedge CLK) begin
        if (run) begin
            f_pc   <= pc;
            f_inst <= imem[fetch_idx];
        end
    end

    // Loading and running at once would corrupt the fetch stream
    a_no_load_while_run: assert property (
        @(posedge CLK) disable iff (RST) !(imem_we && run)
    ) else $error("imem_we asserted while run is high");

endmodule

//--- design/decode_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module decode_stage (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    f_valid,
    input  logic [`XLEN-1:0]        f_pc,
    input  logic [`XLEN-1:0]        f_inst,
    input  logic                    wb_we,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic                    d_valid,
    output logic [`XLEN-1:0]        d_pc,
    output cpu_pkg::alu_op_e        d_alu_op,
    output logic [`REG_ADDR_W-1:0]  d_rs1,
    output logic [`REG_ADDR_W-1:0]  d_rs2,
    output logic [`XLEN-1:0]        d_rs1_val,
    output logic [`XLEN-1:0]        d_rs2_val,
    output logic [`XLEN-1:0]        d_imm,
    output logic                    d_use_imm,
    output logic                    d_is_load,
    output logic                    d_is_store,
    output logic [`REG_ADDR_W-1:0]  d_rd,
    output logic                    d_rd_we
);

    cpu_pkg::opcode_e        opcode;
    cpu_pkg::alu_op_e        alu_op;
    logic [2:0]              funct3;
    logic [`REG_ADDR_W-1:0]  rs1, rs2, rd;
    logic [`XLEN-1:0]        imm_i, imm_s, imm;
    logic [`XLEN-1:0]        rs1_val, rs2_val;
    logic                    use_imm, is_load, is_store, writes;
    logic [`XLEN-1:0]        regs [32];

    // funct3 to ALU op; alt is funct7 bit 30, sub_ok only for R-type
    function automatic cpu_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                                 input logic sub_ok);
        case (f3)
            3'b000:  alu_sel = (alt && sub_ok) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  alu_sel = cpu_pkg::ALU_SLL;
            3'b010:  alu_sel = cpu_pkg::ALU_SLT;
            3'b011:  alu_sel = cpu_pkg::ALU_SLTU;
            3'b100:  alu_sel = cpu_pkg::ALU_XOR;
            3'b101:  alu_sel = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  alu_sel = cpu_pkg::ALU_OR;
            default: alu_sel = cpu_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = cpu_pkg::opcode_e'(f_inst[6:0]);
    assign funct3 = f_inst[14:12];
    assign rd     = f_inst[11:7];
    assign rs1    = f_inst[19:15];
    assign rs2    = f_inst[24:20];
    assign imm_i  = {{20{f_inst[31]}}, f_inst[31:20]};
    assign imm_s  = {{20{f_inst[31]}}, f_inst[31:25], f_inst[11:7]};

    always_comb begin
        alu_op   = cpu_pkg::ALU_ADD; // Unsupported opcodes become a no-op add
        imm      = imm_i;
        use_imm  = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        writes   = 1'b0;
        case (opcode)
            cpu_pkg::OP_REG: begin
                alu_op = alu_sel(funct3, f_inst[30], 1'b1);
                writes = 1'b1;
            end
            cpu_pkg::OP_IMM: begin
                alu_op  = alu_sel(funct3, f_inst[30], 1'b0);
                use_imm = 1'b1;
                writes  = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                writes  = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                imm      = imm_s;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // Register file reads with write-through from writeback
    assign rs1_val = (wb_we && wb_rd == rs1 && rs1 != '0) ? wb_data : regs[rs1];
    assign rs2_val = (wb_we && wb_rd == rs2 && rs2 != '0) ? wb_data : regs[rs2];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data; // x0 stays zero
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            d_valid    <= 1'b0;
            d_rd_we    <= 1'b0;
            d_is_load  <= 1'b0;
            d_is_store <= 1'b0;
        end else begin
            d_valid    <= f_valid;
            d_rd_we    <= f_valid && writes && rd != '0;
            d_is_load  <= f_valid && is_load;
            d_is_store <= f_valid && is_store;
        end
    end

    always_ff @(posedge CLK) begin
        d_pc      <= f_pc;
        d_alu_op  <= alu_op;
        d_rs1     <= rs1;
        d_rs2     <= rs2;
        d_rs1_val <= rs1_val;
        d_rs2_val <= rs2_val;
        d_imm     <= imm;
        d_use_imm <= use_imm;
        d_rd      <= rd;
    end

    // Write enable to x0 never comes back through the pipeline
    a_no_x0_write: assert property (
        @(posedge CLK) disable iff (RST) wb_we |-> wb_rd != '0
    ) else $error("write-back enabled a write to x0");

endmodule

//--- design/execute_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module execute_stage (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    d_valid,
    input  logic [`XLEN-1:0]        d_pc,
    input  cpu_pkg::alu_op_e        d_alu_op,
    input  logic [`REG_ADDR_W-1:0]  d_rs1,
    input  logic [`REG_ADDR_W-1:0]  d_rs2,
    input  logic [`XLEN-1:0]        d_rs1_val,
    input  logic [`XLEN-1:0]        d_rs2_val,
    input  logic [`XLEN-1:0]        d_imm,
    input  logic                    d_use_imm,
    input  logic                    d_is_load,
    input  logic                    d_is_store,
    input  logic [`REG_ADDR_W-1:0]  d_rd,
    input  logic                    d_rd_we,
    input  logic                    wb_we,
    input  logic [`REG_ADDR_W-1:0]  wb_rd,
    input  logic [`XLEN-1:0]        wb_data,
    output logic                    e_valid,
    output logic [`XLEN-1:0]        e_pc,
    output logic [`XLEN-1:0]        e_result,
    output logic [`XLEN-1:0]        e_store_data,
    output logic                    e_is_load,
    output logic                    e_is_store,
    output logic [`REG_ADDR_W-1:0]  e_rd,
    output logic                    e_rd_we
);

    logic [`XLEN-1:0] op_a, rs2_fwd, op_b, alu_out;
    logic [4:0]       shamt;

    // Bypass from the instruction now in memory/writeback
    assign op_a    = (wb_we && wb_rd == d_rs1 && d_rs1 != '0) ? wb_data : d_rs1_val;
    assign rs2_fwd = (wb_we && wb_rd == d_rs2 && d_rs2 != '0) ? wb_data : d_rs2_val;
    assign op_b    = d_use_imm ? d_imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (d_alu_op)
            cpu_pkg::ALU_ADD:  alu_out = op_a + op_b; // Also load/store address
            cpu_pkg::ALU_SUB:  alu_out = op_a - op_b;
            cpu_pkg::ALU_SLL:  alu_out = op_a << shamt;
            cpu_pkg::ALU_SLT:  alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::ALU_SLTU: alu_out = {31'd0, op_a < op_b};
            cpu_pkg::ALU_XOR:  alu_out = op_a ^ op_b;
            cpu_pkg::ALU_SRL:  alu_out = op_a >> shamt;
            cpu_pkg::ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_OR:   alu_out = op_a | op_b;
            cpu_pkg::ALU_AND:  alu_out = op_a & op_b;
            default:           alu_out = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            e_valid    <= 1'b0;
            e_is_load  <= 1'b0;
            e_is_store <= 1'b0;
            e_rd_we    <= 1'b0;
        end else begin
            e_valid    <= d_valid;
            e_is_load  <= d_valid && d_is_load;
            e_is_store <= d_valid && d_is_store;
            e_rd_we    <= d_valid && d_rd_we;
        end
    end

    always_ff @(posedge CLK) begin
        e_pc         <= d_pc;
        e_result     <= alu_out;
        e_store_data <= rs2_fwd; // Store data sees the bypass too
        e_rd         <= d_rd;
    end

    a_alu_op_known: assert property (
        @(posedge CLK) disable iff (RST)
        d_valid |-> (!$isunknown(d_alu_op) && d_alu_op <= cpu_pkg::ALU_AND)
    ) else $error("unknown ALU op on a valid instruction");

endmodule

//--- design/memory_stage.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module memory_stage (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    e_valid,
    input  logic [`XLEN-1:0]        e_pc,
    input  logic [`XLEN-1:0]        e_result,
    input  logic [`XLEN-1:0]        e_store_data,
    input  logic                    e_is_load,
    input  logic                    e_is_store,
    input  logic [`REG_ADDR_W-1:0]  e_rd,
    input  logic                    e_rd_we,
    output logic                    wb_we,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        wb_data,
    output logic                    retire_valid,
    output logic [`XLEN-1:0]        retire_pc,
    output logic                    retire_we,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    logic [`XLEN-1:0]    dmem [`DMEM_DEPTH];
    logic [`DMEM_AW-1:0] dmem_idx;
    logic [`XLEN-1:0]    load_data;

    assign dmem_idx  = e_result[`DMEM_AW+1:2]; // Address wraps at memory size
    assign load_data = dmem[dmem_idx];

    always_ff @(posedge CLK) begin
        if (e_valid && e_is_store) begin
            dmem[dmem_idx] <= e_store_data;
        end
    end

    // Writeback, also the bypass source for execute
    assign wb_we   = e_valid && e_rd_we;
    assign wb_rd   = e_rd;
    assign wb_data = e_is_load ? load_data : e_result;

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= e_valid;
            retire_we    <= wb_we;
        end
    end

    always_ff @(posedge CLK) begin
        retire_pc   <= e_pc;
        retire_rd   <= wb_we ? e_rd : '0; // Zero when nothing is written
        retire_data <= wb_we ? wb_data : '0;
    end

    a_word_aligned: assert property (
        @(posedge CLK) disable iff (RST)
        (e_valid && (e_is_load || e_is_store)) |-> e_result[1:0] == 2'b00
    ) else $error("misaligned data access at %h", e_result);

endmodule

//--- design/rv_core.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module rv_core (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    run,
    input  logic                    imem_we,
    input  logic [`IMEM_AW-1:0]     imem_addr,
    input  logic [`XLEN-1:0]        imem_wdata,
    output logic                    retire_valid,
    output logic [`XLEN-1:0]        retire_pc,
    output logic                    retire_we,
    output logic [`REG_ADDR_W-1:0]  retire_rd,
    output logic [`XLEN-1:0]        retire_data
);

    // Fetch to decode
    logic                   f_valid;
    logic [`XLEN-1:0]       f_pc, f_inst;

    // Decode to execute
    logic                   d_valid, d_use_imm, d_is_load, d_is_store, d_rd_we;
    logic [`XLEN-1:0]       d_pc, d_rs1_val, d_rs2_val, d_imm;
    cpu_pkg::alu_op_e       d_alu_op;
    logic [`REG_ADDR_W-1:0] d_rs1, d_rs2, d_rd;

    // Execute to memory
    logic                   e_valid, e_is_load, e_is_store, e_rd_we;
    logic [`XLEN-1:0]       e_pc, e_result, e_store_data;
    logic [`REG_ADDR_W-1:0] e_rd;

    // Writeback and bypass
    logic                   wb_we;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    fetch_stage fetch_inst (
        .CLK(CLK), .RST(RST), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .f_valid(f_valid), .f_pc(f_pc), .f_inst(f_inst)
    );

    decode_stage decode_inst (
        .CLK(CLK), .RST(RST),
        .f_valid(f_valid), .f_pc(f_pc), .f_inst(f_inst),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .d_valid(d_valid), .d_pc(d_pc), .d_alu_op(d_alu_op),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val),
        .d_imm(d_imm), .d_use_imm(d_use_imm), .d_is_load(d_is_load),
        .d_is_store(d_is_store), .d_rd(d_rd), .d_rd_we(d_rd_we)
    );

    execute_stage execute_inst (
        .CLK(CLK), .RST(RST),
        .d_valid(d_valid), .d_pc(d_pc), .d_alu_op(d_alu_op),
        .d_rs1(d_rs1), .d_rs2(d_rs2), .d_rs1_val(d_rs1_val), .d_rs2_val(d_rs2_val),
        .d_imm(d_imm), .d_use_imm(d_use_imm), .d_is_load(d_is_load),
        .d_is_store(d_is_store), .d_rd(d_rd), .d_rd_we(d_rd_we),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .e_valid(e_valid), .e_pc(e_pc), .e_result(e_result), .e_store_data(e_store_data),
        .e_is_load(e_is_load), .e_is_store(e_is_store), .e_rd(e_rd), .e_rd_we(e_rd_we)
    );

    memory_stage memory_inst (
        .CLK(CLK), .RST(RST),
        .e_valid(e_valid), .e_pc(e_pc), .e_result(e_result), .e_store_data(e_store_data),
        .e_is_load(e_is_load), .e_is_store(e_is_store), .e_rd(e_rd), .e_rd_we(e_rd_we),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

endmodule

//--- verif/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD = 10
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always #(PERIOD / 2) CLK = ~CLK; // 50% duty cycle

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/100ps
`include "cpu_config.svh"

module tb_rv_core;

    localparam int          PROG_LEN       = 120;
    localparam int          START_TIMEOUT  = 400; // Cycles until run is first seen high
    localparam int          RETIRE_TIMEOUT = 20;  // Cycles between two retirements
    localparam logic [31:0] SEED           = 32'h294d;

    logic                    CLK, RST, run, imem_we;
    logic [`IMEM_AW-1:0]     imem_addr;
    logic [`XLEN-1:0]        imem_wdata;
    logic                    retire_valid, retire_we;
    logic [`XLEN-1:0]        retire_pc, retire_data;
    logic [`REG_ADDR_W-1:0]  retire_rd;

    logic [31:0] prog [`IMEM_DEPTH];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [`DMEM_DEPTH];
    logic        exp_we [PROG_LEN];
    logic [4:0]  exp_rd [PROG_LEN];
    logic [31:0] exp_data [PROG_LEN];
    int          edge_cnt = 0;
    int          fetch_edges [$];

    clock_gen clock_gen_inst (.CLK(CLK));

    rv_core rv_core_inst (
        .CLK(CLK), .RST(RST), .run(run),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, cpu_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OP_STORE};
    endfunction

    // ISA model, one instruction per call on ref_regs and ref_mem
    function automatic void ref_step(input logic [31:0] inst, output logic we,
                                     output logic [4:0] rd, output logic [31:0] data);
        logic [31:0] a, b, imm_i, imm_s, addr;
        logic [4:0]  sh;
        logic        alt;
        a     = ref_regs[inst[19:15]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        b     = (inst[6:0] == cpu_pkg::OP_REG) ? ref_regs[inst[24:20]] : imm_i;
        sh    = b[4:0];
        alt   = inst[30] && (inst[6:0] == cpu_pkg::OP_REG || inst[14:12] == 3'b101);
        rd    = inst[11:7];
        we    = 1'b0;
        data  = '0;
        case (inst[6:0])
            cpu_pkg::OP_REG, cpu_pkg::OP_IMM: begin
                we = 1'b1;
                case (inst[14:12])
                    3'b000:  data = alt ? a - b : a + b; // sub only for R-type
                    3'b001:  data = a << sh;
                    3'b010:  data = {31'd0, $signed(a) < $signed(b)};
                    3'b011:  data = {31'd0, a < b};
                    3'b100:  data = a ^ b;
                    3'b101: begin
                        if (alt) begin
                            data = $signed(a) >>> sh;
                        end else begin
                            data = a >> sh;
                        end
                    end
                    3'b110:  data = a | b;
                    default: data = a & b;
                endcase
            end
            cpu_pkg::OP_LOAD: begin
                we   = 1'b1;
                addr = a + imm_i;
                data = ref_mem[addr[`DMEM_AW+1:2]];
            end
            cpu_pkg::OP_STORE: begin
                addr = a + imm_s;
                ref_mem[addr[`DMEM_AW+1:2]] = ref_regs[inst[24:20]];
            end
            default: ; // Anything else is a no-op
        endcase
        if (rd == 5'd0) begin
            we = 1'b0;
        end
        if (we) begin
            ref_regs[rd] = data;
        end
    endfunction

    task automatic gen_program();
        int          n, kind, word;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic        alt;
        n = 0;
        for (int r = 1; r <= 8; r++) begin
            prog[n] = enc_i(12'($urandom()), 5'd0, 3'b000, 5'(r), cpu_pkg::OP_IMM);
            n++;
        end
        for (int w = 0; w < 16; w++) begin
            prog[n] = enc_s(12'(w * 4), 5'(1 + w % 8), 5'd0); // Data words 0 to 15
            n++;
        end
        while (n < PROG_LEN) begin
            kind = $urandom_range(0, 9);
            rd   = 5'($urandom_range(0, 7)); // Few registers, many dependencies
            rs1  = 5'($urandom_range(0, 7));
            rs2  = 5'($urandom_range(0, 7));
            f3   = 3'($urandom_range(0, 7));
            imm  = 12'($urandom());
            alt  = 1'($urandom_range(0, 1));
            word = $urandom_range(0, 15);
            if (kind <= 3) begin
                f7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                prog[n] = enc_r(f7, rs2, rs1, f3, rd);
            end else if (kind <= 6) begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11:5] = (alt && f3 == 3'b101) ? 7'h20 : 7'h00; // Shift encodings
                end
                prog[n] = enc_i(imm, rs1, f3, rd, cpu_pkg::OP_IMM);
            end else if (kind == 9) begin
                prog[n] = {imm, rs1, f3, rd, 7'b1100011}; // Branch opcode, unsupported
            end else if (n + 1 < PROG_LEN) begin
                if (kind == 8) begin
                    prog[n] = enc_s(12'(word * 4), rs2, 5'd0);
                    n++;
                    prog[n] = enc_i(12'(word * 4), 5'd0, 3'b010, rd, cpu_pkg::OP_LOAD);
                end else begin
                    prog[n] = enc_i(12'(word * 4), 5'd0, 3'b010, rd, cpu_pkg::OP_LOAD);
                    n++;
                    prog[n] = enc_r(7'h00, rs2, rd, 3'b000, rs1); // Uses the loaded value
                end
            end else begin
                prog[n] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, cpu_pkg::OP_IMM);
            end
            n++;
        end
        for (int i = PROG_LEN; i < `IMEM_DEPTH; i++) begin
            prog[i] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, cpu_pkg::OP_IMM);
        end
    endtask

    task automatic build_expected();
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        for (int w = 0; w < `DMEM_DEPTH; w++) begin
            ref_mem[w] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            ref_step(prog[i], exp_we[i], exp_rd[i], exp_data[i]);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_retire(input int idx);
        int t;
        t = 0;
        @(negedge CLK);
        while (retire_valid !== 1'b1) begin
            t++;
            if (t > RETIRE_TIMEOUT) begin
                abort_run($sformatf("retirement %0d at pc %h never came", idx, idx * 4));
            end
            @(negedge CLK);
        end
    endtask

    // Edge count, and every edge that samples run high
    always @(posedge CLK) begin
        edge_cnt <= edge_cnt + 1;
        if (run) begin
            fetch_edges.push_back(edge_cnt + 1);
        end
    end

    initial begin
        RST        = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        void'($urandom(SEED));
        gen_program();
        build_expected();
        repeat (10) @(posedge CLK);
        RST <= 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            @(posedge CLK);
            imem_we    <= 1'b1;
            imem_addr  <= `IMEM_AW'(i);
            imem_wdata <= prog[i];
        end
        @(posedge CLK);
        imem_we <= 1'b0;
        @(posedge CLK);
        run <= 1'b1;
        repeat (50) @(posedge CLK);
        run <= 1'b0; // Pause mid-program
        repeat (5) @(posedge CLK);
        run <= 1'b1;
    end

    initial begin : compare_retire
        int t;
        t = 0;
        while (fetch_edges.size() == 0) begin
            @(negedge CLK);
            t++;
            if (t > START_TIMEOUT) begin
                abort_run("run was never sampled high by the core");
            end
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            wait_retire(i);
            // Retires on the fourth edge counted from its fetch edge
            check_value("retire_valid edge", 32'(edge_cnt), 32'(fetch_edges[i] + 3));
            check_value("retire_pc", retire_pc, 32'(i * 4));
            check_value("retire_we", {31'd0, retire_we}, {31'd0, exp_we[i]});
            if (exp_we[i]) begin
                check_value("retire_rd", {27'd0, retire_rd}, {27'd0, exp_rd[i]});
                check_value("retire_data", retire_data, exp_data[i]);
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_core.sv
verif/clock_gen.sv
verif/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_rv_core \
    -o sim_rv_core

./obj_dir/sim_rv_core
